//--- dcache_params.svh
// Geometry must stay 4 ways x 16 sets x 64-byte lines with 32-bit addresses; the tag width follows it
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DCACHE_WAYS 4
`define DCACHE_SETS 16
`define DCACHE_LINE_BYTES 64	// 512-bit line
`define DCACHE_ADDR_W 32
`define DCACHE_TAG_W 22	// ADDR_W minus set and offset bits
`define DCACHE_WORD_W 32

// Cycles with rd_hold low between two aging steps
`define DCACHE_LRU_AGE_PERIOD 64

`endif

//--- dcache_pkg.sv
// Types and tag helpers for the L1 data cache; set and line counts must be powers of two
`default_nettype none
`include "dcache_params.svh"

package dcache_pkg;
	localparam int WAYS = `DCACHE_WAYS;
	localparam int SETS = `DCACHE_SETS;
	localparam int OFFSET_W = $clog2(`DCACHE_LINE_BYTES);
	localparam int SET_W = $clog2(`DCACHE_SETS);
	localparam int WORD_SEL_W = $clog2(`DCACHE_LINE_BYTES * 8 / `DCACHE_WORD_W);

	typedef logic [$clog2(WAYS)-1:0] way_t;
	typedef logic [SET_W-1:0] set_t;
	typedef logic [`DCACHE_TAG_W-1:0] tag_t;
	typedef logic [`DCACHE_LINE_BYTES*8-1:0] line_t;
	typedef logic [`DCACHE_LINE_BYTES-1:0] byte_en_t;
	typedef logic [`DCACHE_WORD_W-1:0] word_t;
	typedef logic [`DCACHE_ADDR_W-1:0] addr_t;

	// Status 0 marks an empty line
	typedef enum logic [1:0] {LRU_INVALID, LRU_OLD, LRU_MID, LRU_NEW} lru_status_e;
	typedef enum logic [1:0] {ORDER_BYTE, ORDER_HALF, ORDER_WORD, ORDER_NONE} up_order_e;

	typedef struct packed {
		lru_status_e status;
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		logic hit;
		way_t way;
	} way_match_t;

	typedef tag_entry_t [WAYS-1:0] set_entries_t;	// All ways of one set

	function automatic tag_t addr_tag(addr_t addr);
		return addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
	endfunction

	function automatic set_t addr_set(addr_t addr);
		return addr[OFFSET_W +: SET_W];
	endfunction

	// Lowest matching valid way wins
	function automatic way_match_t tag_lookup(tag_t tag, set_entries_t ways);
		way_match_t match;
		match.hit = 1'b0;
		match.way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (ways[w].status != LRU_INVALID && ways[w].tag == tag) begin
				match.hit = 1'b1;
				match.way = way_t'(w);
			end
		end
		return match;
	endfunction

	// Tag match first, then lowest status, then the last way
	function automatic way_t pick_victim(tag_t tag, set_entries_t ways);
		way_t victim;
		logic found;
		victim = way_t'(WAYS - 1);
		found = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			if (!found && ways[w].tag == tag) begin
				victim = way_t'(w);
				found = 1'b1;
			end
		end
		for (int lvl = 0; lvl < 3; lvl++) begin
			for (int w = 0; w < WAYS; w++) begin
				if (!found && ways[w].status == lru_status_e'(lvl)) begin
					victim = way_t'(w);
					found = 1'b1;
				end
			end
		end
		return victim;
	endfunction
endpackage

`default_nettype wire

//--- dcache_wr_if.sv
// Data RAM write strobe; one bytes write per rising edge while a we bit is high, no acknowledge
`default_nettype none

interface dcache_wr_if import dcache_pkg::*; ();
	logic [WAYS-1:0] we;	// One strobe per way
	set_t set;
	byte_en_t byte_en;
	line_t data;

	// Tag control side
	modport ctrl (
		output we,
		output set,
		output byte_en,
		output data
	);

	// Storage side
	modport ram (
		input we,
		input set,
		input byte_en,
		input data
	);
endinterface

`default_nettype wire

//--- dcache_tag_ctrl.sv
// Upload wins over write; tags survive reset and remove, only status is cleared
`default_nettype none
`include "dcache_params.svh"

module dcache_tag_ctrl import dcache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input logic rd_req,
	input addr_t rd_addr,
	input logic rd_hold,
	input logic up_req,
	input up_order_e up_order,
	input addr_t up_addr,
	input word_t up_data,
	input logic wr_req,
	input addr_t wr_addr,
	input line_t wr_line,
	output logic rd_busy,
	output logic up_busy,
	output logic wr_busy,
	output logic rd_accept,
	output logic rd_step,
	output logic lookup_hit,
	output way_t lookup_way,
	dcache_wr_if.ctrl wr_bus
);
	localparam int AGE_W = $clog2(`DCACHE_LRU_AGE_PERIOD);

	lru_status_e status_q [WAYS][SETS];
	tag_t tag_q [WAYS][SETS];
	logic [AGE_W-1:0] age_cnt;
	logic age_tick;
	set_t rd_set;
	set_t up_set;
	set_t wr_set;
	set_entries_t rd_entries;
	set_entries_t up_entries;
	set_entries_t wr_entries;
	way_match_t rd_match;
	way_match_t up_match;
	way_t victim;

	function automatic byte_en_t upload_be(logic [OFFSET_W-1:0] offset, up_order_e order);
		case (order)
			ORDER_BYTE: return byte_en_t'(1) << offset;
			ORDER_HALF: return byte_en_t'(2'b11) << {offset[OFFSET_W-1:1], 1'b0};
			ORDER_WORD: return byte_en_t'(4'hf) << {offset[OFFSET_W-1:2], 2'b00};
			default: return '0;
		endcase
	endfunction

	function automatic lru_status_e status_up(lru_status_e status);
		return (status == LRU_NEW) ? LRU_NEW : lru_status_e'(status + 2'd1);
	endfunction

	// New and mid lines step down, old and invalid stay
	function automatic lru_status_e status_age(lru_status_e status);
		return (status >= LRU_MID) ? lru_status_e'(status - 2'd1) : status;
	endfunction

	assign rd_set = addr_set(rd_addr);
	assign up_set = addr_set(up_addr);
	assign wr_set = addr_set(wr_addr);

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			rd_entries[w] = '{status: status_q[w][rd_set], tag: tag_q[w][rd_set]};
			up_entries[w] = '{status: status_q[w][up_set], tag: tag_q[w][up_set]};
			wr_entries[w] = '{status: status_q[w][wr_set], tag: tag_q[w][wr_set]};
		end
	end

	assign rd_match = tag_lookup(addr_tag(rd_addr), rd_entries);
	assign up_match = tag_lookup(addr_tag(up_addr), up_entries);
	assign victim = pick_victim(addr_tag(wr_addr), wr_entries);

	assign rd_step = !rd_hold;
	assign rd_busy = rd_hold || (rd_req && wr_req &&
		rd_addr[`DCACHE_ADDR_W-1:OFFSET_W] == wr_addr[`DCACHE_ADDR_W-1:OFFSET_W]);
	assign rd_accept = rd_req && !rd_busy;
	assign lookup_hit = rd_match.hit;
	assign lookup_way = rd_match.way;
	assign wr_busy = up_req;
	assign up_busy = wr_req;

	assign age_tick = rd_step && (age_cnt == AGE_W'(`DCACHE_LRU_AGE_PERIOD - 1));

	// Data RAM request; an upload miss strobes no way
	always_comb begin
		wr_bus.we = '0;
		wr_bus.set = wr_set;
		wr_bus.byte_en = '1;
		wr_bus.data = wr_line;
		if (up_req) begin
			wr_bus.set = up_set;
			wr_bus.byte_en = upload_be(up_addr[OFFSET_W-1:0], up_order);
			wr_bus.data = {($bits(line_t) / $bits(word_t)){up_data}};
			wr_bus.we[up_match.way] = up_match.hit;
		end else if (wr_req) begin
			wr_bus.we[victim] = 1'b1;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					status_q[w][s] <= LRU_INVALID;
				end
			end
			age_cnt <= '0;
		end else if (remove) begin
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					status_q[w][s] <= LRU_INVALID;
				end
			end
			age_cnt <= '0;
		end else begin
			if (rd_step) begin
				age_cnt <= age_tick ? '0 : age_cnt + 1'b1;
			end
			if (up_req) begin
				if (up_match.hit) begin
					status_q[up_match.way][up_set] <= status_up(status_q[up_match.way][up_set]);
				end
			end else if (wr_req) begin
				status_q[victim][wr_set] <= LRU_NEW;
			end else begin
				if (age_tick) begin
					for (int w = 0; w < WAYS; w++) begin
						for (int s = 0; s < SETS; s++) begin
							status_q[w][s] <= status_age(status_q[w][s]);
						end
					end
				end
				if (rd_accept && rd_match.hit) begin
					status_q[rd_match.way][rd_set] <= LRU_NEW;	// Overrides aging of this line
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (wr_req && !up_req) begin
			tag_q[victim][wr_set] <= addr_tag(wr_addr);
		end
	end
endmodule

`default_nettype wire

//--- dcache_data_ram.sv
// Line storage without reset; read is combinational, a read of a line written at the same edge sees new data
`default_nettype none

module dcache_data_ram import dcache_pkg::*; (
	input logic iCLOCK,
	input set_t rd_set,
	input way_t rd_way,
	output line_t rd_line,
	dcache_wr_if.ram wr_bus
);
	line_t way_line [WAYS];

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		line_t mem [SETS];

		// Byte lanes written under the way strobe
		always_ff @(posedge iCLOCK) begin
			for (int b = 0; b < $bits(byte_en_t); b++) begin
				if (wr_bus.we[w] && wr_bus.byte_en[b]) begin
					mem[wr_bus.set][b*8 +: 8] <= wr_bus.data[b*8 +: 8];
				end
			end
		end

		assign way_line[w] = mem[rd_set];
	end

	assign rd_line = way_line[rd_way];	// Way mux
endmodule

`default_nettype wire

//--- dcache_read_port.sv
// One register stage; while rd_step is low the stored result is kept and all outputs read zero
`default_nettype none

module dcache_read_port import dcache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input addr_t rd_addr,
	input logic rd_accept,
	input logic rd_step,
	input logic lookup_hit,
	input way_t lookup_way,
	input line_t rd_line,
	output set_t rd_set,
	output way_t rd_way,
	output logic rd_valid,
	output logic rd_hit,
	output word_t rd_data
);
	logic valid_q;
	logic hit_q;
	logic [WORD_SEL_W-1:0] word_q;
	word_t sel_word;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			hit_q <= 1'b0;
		end else if (remove) begin
			valid_q <= 1'b0;
			hit_q <= 1'b0;
		end else if (rd_step) begin
			valid_q <= rd_accept;
			hit_q <= lookup_hit;
		end
	end

	// Line address of the request, kept for the RAM read
	always_ff @(posedge iCLOCK) begin
		if (rd_step) begin
			rd_way <= lookup_way;
			rd_set <= addr_set(rd_addr);
			word_q <= rd_addr[OFFSET_W-1 -: WORD_SEL_W];
		end
	end

	assign sel_word = rd_line[word_q * $bits(word_t) +: $bits(word_t)];

	assign rd_valid = valid_q && rd_step;
	assign rd_hit = valid_q && hit_q && rd_step;
	assign rd_data = rd_hit ? sel_word : '0;	// Zero on miss or hold
endmodule

`default_nettype wire

//--- dcache_top.sv
// 4-way L1 data cache; rd_busy is combinational and a request raised while it is high is dropped
`default_nettype none

module dcache_top import dcache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input logic rd_req,
	output logic rd_busy,
	input addr_t rd_addr,
	input logic rd_hold,
	output logic rd_valid,
	output logic rd_hit,
	output word_t rd_data,
	input logic up_req,
	output logic up_busy,
	input up_order_e up_order,
	input addr_t up_addr,
	input word_t up_data,
	input logic wr_req,
	output logic wr_busy,
	input addr_t wr_addr,
	input line_t wr_line
);
	logic rd_accept;
	logic rd_step;
	logic lookup_hit;
	way_t lookup_way;
	set_t rd_set;
	way_t rd_way;
	line_t rd_line;

	dcache_wr_if wr_bus ();

	// Tags, status and arbitration
	dcache_tag_ctrl u_tag_ctrl (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.remove (remove),
		.rd_req (rd_req),
		.rd_addr (rd_addr),
		.rd_hold (rd_hold),
		.up_req (up_req),
		.up_order (up_order),
		.up_addr (up_addr),
		.up_data (up_data),
		.wr_req (wr_req),
		.wr_addr (wr_addr),
		.wr_line (wr_line),
		.rd_busy (rd_busy),
		.up_busy (up_busy),
		.wr_busy (wr_busy),
		.rd_accept (rd_accept),
		.rd_step (rd_step),
		.lookup_hit (lookup_hit),
		.lookup_way (lookup_way),
		.wr_bus (wr_bus.ctrl)
	);

	dcache_data_ram u_data_ram (
		.iCLOCK (iCLOCK),
		.rd_set (rd_set),
		.rd_way (rd_way),
		.rd_line (rd_line),
		.wr_bus (wr_bus.ram)
	);

	// Registered result and word select
	dcache_read_port u_read_port (
		.iCLOCK (iCLOCK),
		.inRESET (inRESET),
		.remove (remove),
		.rd_addr (rd_addr),
		.rd_accept (rd_accept),
		.rd_step (rd_step),
		.lookup_hit (lookup_hit),
		.lookup_way (lookup_way),
		.rd_line (rd_line),
		.rd_set (rd_set),
		.rd_way (rd_way),
		.rd_valid (rd_valid),
		.rd_hit (rd_hit),
		.rd_data (rd_data)
	);
endmodule

`default_nettype wire

//--- dcache_properties.sv
// Output rules of the read port; checks are disabled while inRESET is low
`default_nettype none

module dcache_properties import dcache_pkg::*; (
	input logic iCLOCK,
	input logic inRESET,
	input logic remove,
	input logic rd_valid,
	input logic rd_hit,
	input word_t rd_data
);
	timeunit 1ns;
	timeprecision 1ps;

	hit_has_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_hit |-> rd_valid)
		else $error("rd_hit high while rd_valid is low");

	// Data is gated on a miss or hold
	miss_data_zero: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!rd_hit |-> rd_data == '0)
		else $error("rd_data not zero while rd_hit is low");

	remove_clears_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		remove |=> !rd_valid)
		else $error("rd_valid high in the cycle after remove");
endmodule

bind dcache_top dcache_properties u_properties (
	.iCLOCK (iCLOCK),
	.inRESET (inRESET),
	.remove (remove),
	.rd_valid (rd_valid),
	.rd_hit (rd_hit),
	.rd_data (rd_data)
);

`default_nettype wire

//--- dcache_tb.sv
// Directed checks of the 4-way data cache; expects the 64-cycle aging period and an empty set 9
`default_nettype none
`include "dcache_params.svh"

module dcache_tb import dcache_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WATCHDOG_NS = (40 * `DCACHE_LRU_AGE_PERIOD + 2000) * 10;

	logic iCLOCK;
	logic inRESET;
	logic remove;
	logic rd_req;
	logic rd_busy;
	addr_t rd_addr;
	logic rd_hold;
	logic rd_valid;
	logic rd_hit;
	word_t rd_data;
	logic up_req;
	logic up_busy;
	up_order_e up_order;
	addr_t up_addr;
	word_t up_data;
	logic wr_req;
	logic wr_busy;
	addr_t wr_addr;
	line_t wr_line;
	line_t model [addr_t];	// Cached lines by line address
	int errors = 0;
	int checks = 0;

	dcache_top u_dcache_top (.*);

	always #5 iCLOCK = ~iCLOCK;

	function automatic addr_t make_addr(input int tag, input int set, input int off);
		return (addr_t'(tag) << 10) | (addr_t'(set) << 6) | addr_t'(off);
	endfunction

	function automatic addr_t line_of(input addr_t addr);
		return {addr[31:6], 6'b0};
	endfunction

	function automatic line_t random_line();
		line_t data;
		for (int i = 0; i < 16; i++) begin
			data[i*32 +: 32] = $urandom();
		end
		return data;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic write_line(input addr_t addr, input line_t data);
		wr_req = 1'b1;
		wr_addr = addr;
		wr_line = data;
		@(negedge iCLOCK);
		compare("wr_busy", wr_busy, 0);
		@(posedge iCLOCK);
		#1;
		wr_req = 1'b0;
		model[line_of(addr)] = data;
	endtask

	// Merge follows the order rule with the word repeated over the line
	task automatic upload(input addr_t addr, input up_order_e order, input word_t data);
		int count;
		int first;
		line_t merged;
		up_req = 1'b1;
		up_addr = addr;
		up_order = order;
		up_data = data;
		@(negedge iCLOCK);
		compare("up_busy", up_busy, 0);
		@(posedge iCLOCK);
		#1;
		up_req = 1'b0;
		count = (order == ORDER_BYTE) ? 1 : (order == ORDER_HALF) ? 2 : (order == ORDER_WORD) ? 4 : 0;
		if (count != 0 && model.exists(line_of(addr))) begin
			first = int'(addr[5:0]) & ~(count - 1);
			merged = model[line_of(addr)];
			for (int b = first; b < first + count; b++) begin
				merged[b*8 +: 8] = data[(b % 4)*8 +: 8];
			end
			model[line_of(addr)] = merged;
		end
	endtask

	task automatic read_check(input addr_t addr);
		int waited;
		logic exp_hit;
		word_t exp_word;
		line_t exp_line;
		waited = 0;
		exp_hit = model.exists(line_of(addr));
		exp_line = exp_hit ? model[line_of(addr)] : '0;
		exp_word = exp_line[addr[5:2]*32 +: 32];
		rd_req = 1'b1;
		rd_addr = addr;
		@(negedge iCLOCK);
		while (rd_busy && waited < 20) begin
			@(negedge iCLOCK);
			waited++;
		end
		if (rd_busy) begin
			errors++;
			$display("Read of %h was never accepted, rd_busy stuck high", addr);
		end
		@(posedge iCLOCK);
		#1;
		rd_req = 1'b0;
		@(negedge iCLOCK);
		compare("rd_valid", rd_valid, 1);
		compare("rd_hit", rd_hit, exp_hit);
		compare("rd_data", rd_data, exp_word);
		@(posedge iCLOCK);
		#1;
	endtask

	task automatic read_line(input addr_t base);
		for (int off = 0; off < 64; off += 4) begin
			read_check(base + addr_t'(off));
		end
	endtask

	task automatic test_reset_miss();
		@(negedge iCLOCK);
		compare("rd_valid", rd_valid, 0);
		@(posedge iCLOCK);
		#1;
		read_check(make_addr(22'h1234, 3, 8));
	endtask

	task automatic test_fill_read();
		for (int w = 0; w < 4; w++) begin
			write_line(make_addr(22'h100 + w, 5, 0), random_line());	// Ways 0 to 3 in turn
		end
		for (int w = 0; w < 4; w++) begin
			read_line(make_addr(22'h100 + w, 5, 0));
		end
	endtask

	task automatic test_upload();
		addr_t base;
		base = make_addr(22'h100, 5, 0);
		upload(base + 3, ORDER_BYTE, $urandom());
		upload(base + 10, ORDER_HALF, $urandom());
		upload(base + 20, ORDER_WORD, $urandom());
		read_line(base);
		upload(make_addr(22'h2aa, 7, 4), ORDER_WORD, $urandom());	// Tag never filled
		read_check(make_addr(22'h2aa, 7, 4));
	endtask

	task automatic test_aging_victim();
		for (int w = 0; w < 4; w++) begin
			write_line(make_addr(22'h200 + w, 9, 0), random_line());
		end
		repeat (3 * `DCACHE_LRU_AGE_PERIOD) @(posedge iCLOCK);
		#1;
		read_check(make_addr(22'h200, 9, 0));	// Way 0 back to newest
		write_line(make_addr(22'h204, 9, 0), random_line());
		model.delete(make_addr(22'h201, 9, 0));	// Lowest old way is way 1
		for (int w = 0; w < 5; w++) begin
			read_check(make_addr(22'h200 + w, 9, 4 * w));
		end
	endtask

	task automatic test_hold_collision();
		addr_t addr;
		word_t exp_word;
		line_t fresh;
		addr = make_addr(22'h202, 9, 12);
		exp_word = model[line_of(addr)][3*32 +: 32];
		rd_req = 1'b1;
		rd_addr = addr;
		@(posedge iCLOCK);
		#1;
		rd_req = 1'b0;
		rd_hold = 1'b1;
		repeat (3) begin
			@(negedge iCLOCK);
			compare("rd_valid", rd_valid, 0);
			compare("rd_busy", rd_busy, 1);
		end
		@(posedge iCLOCK);
		#1;
		rd_hold = 1'b0;
		@(negedge iCLOCK);
		compare("rd_valid", rd_valid, 1);
		compare("rd_hit", rd_hit, 1);
		compare("rd_data", rd_data, exp_word);
		@(posedge iCLOCK);
		#1;
		// Same line on both ports
		addr = make_addr(22'h203, 9, 0);
		fresh = random_line();
		rd_req = 1'b1;
		rd_addr = addr + 8;
		wr_req = 1'b1;
		wr_addr = addr;
		wr_line = fresh;
		@(negedge iCLOCK);
		compare("rd_busy", rd_busy, 1);
		compare("up_busy", up_busy, 1);	// Write pending blocks uploads
		@(posedge iCLOCK);
		#1;
		rd_req = 1'b0;
		wr_req = 1'b0;
		model[addr] = fresh;
		@(negedge iCLOCK);
		compare("rd_valid", rd_valid, 0);	// Request was not taken
		@(posedge iCLOCK);
		#1;
		read_check(addr + 8);
	endtask

	task automatic test_remove();
		addr_t lines [$];
		rd_req = 1'b1;
		rd_addr = make_addr(22'h200, 9, 0);	// Filled line, a hit without remove
		remove = 1'b1;
		@(posedge iCLOCK);
		#1;
		rd_req = 1'b0;
		remove = 1'b0;
		@(negedge iCLOCK);
		compare("rd_valid", rd_valid, 0);
		compare("rd_hit", rd_hit, 0);
		@(posedge iCLOCK);
		#1;
		foreach (model[key]) begin
			lines.push_back(key);
		end
		model.delete();
		foreach (lines[i]) begin
			read_check(lines[i] + addr_t'(4 * i % 64));
		end
	endtask

	initial begin
		void'($urandom(32'hb6bedfc3));
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		remove = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		rd_hold = 1'b0;
		up_req = 1'b0;
		up_order = ORDER_NONE;
		up_addr = '0;
		up_data = '0;
		wr_req = 1'b0;
		wr_addr = '0;
		wr_line = '0;
		repeat (3) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		test_reset_miss();
		test_fill_read();
		test_upload();
		test_aging_victim();
		test_hold_collision();
		test_remove();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("Checks %0d, errors %0d", checks, errors);
		$display("test failed");
		$finish;
	end
endmodule

`default_nettype wire

//--- src.f
+incdir+.
dcache_pkg.sv
dcache_wr_if.sv
dcache_tag_ctrl.sv
dcache_data_ram.sv
dcache_read_port.sv
dcache_top.sv
dcache_properties.sv
dcache_tb.sv
